//--- ec_field_pkg.sv
// ==================================================
// Field element width, prime modulus and fold value
// ==================================================
package ec_field_pkg;

  // Every coordinate and every intermediate value is one field element
  localparam int FE_W = 16;

  // Largest prime below 2^16
  localparam logic [FE_W-1:0] FE_P = 16'd65521;

  // 2^16 mod P
  // A product hi*2^16 + lo reduces to hi*15 + lo
  localparam logic [FE_W-1:0] FE_FOLD = 16'd15;

endpackage

//--- ec_padd_pkg.sv
// ==================================================
// Point-add schedule tags, masks and FSM codes
// ==================================================
package ec_padd_pkg;

  localparam int TAG_W = 5;   // Tag travels with each field operation
  localparam int N_EQ  = 24;  // Steps in the schedule

  // Screen for infinity, inverse and equal points on acceptance
  localparam bit CHK_INPUT = 1'b1;

  // Step index, also the temp register that receives the result
  localparam logic [TAG_W-1:0]
    EQ_Z2SQ   = 5'd0,   // Z2^2
    EQ_U1     = 5'd1,   // X1*Z2^2
    EQ_Z1SQ   = 5'd2,   // Z1^2
    EQ_U2     = 5'd3,   // X2*Z1^2
    EQ_Z2CU   = 5'd4,   // Z2^3
    EQ_S1     = 5'd5,   // Y1*Z2^3
    EQ_Z1CU   = 5'd6,   // Z1^3
    EQ_S2     = 5'd7,   // Y2*Z1^3
    EQ_H      = 5'd8,   // U2 - U1
    EQ_R      = 5'd9,   // S2 - S1
    EQ_R2     = 5'd10,  // R^2
    EQ_H2     = 5'd11,  // H^2
    EQ_H3     = 5'd12,  // H^3
    EQ_X3A    = 5'd13,  // R^2 - H^3
    EQ_U1H2   = 5'd14,  // U1*H^2
    EQ_U1H2X2 = 5'd15,  // 2*U1*H^2, done as an add
    EQ_X3     = 5'd16,  // Final X
    EQ_RU     = 5'd17,  // R*U1*H^2
    EQ_RX3    = 5'd18,  // R*X3
    EQ_S1H3   = 5'd19,  // S1*H^3
    EQ_Y3A    = 5'd20,  // R*(U1*H^2 - X3)
    EQ_Y3     = 5'd21,  // Final Y
    EQ_Z12    = 5'd22,  // Z1*Z2
    EQ_Z3     = 5'd23;  // Final Z

  // Steps that run on the adder/subtractor, the rest go to the multiplier
  localparam logic [N_EQ-1:0] EQ_AS_MASK =
    (N_EQ'(1) << EQ_H) | (N_EQ'(1) << EQ_R) | (N_EQ'(1) << EQ_X3A) |
    (N_EQ'(1) << EQ_U1H2X2) | (N_EQ'(1) << EQ_X3) | (N_EQ'(1) << EQ_Y3A) |
    (N_EQ'(1) << EQ_Y3);

  // Sequencer FSM
  localparam logic [1:0]
    ST_IDLE = 2'd0,
    ST_BUSY = 2'd1,
    ST_DONE = 2'd2;

endpackage

//--- fp_mod_mul.sv
// ==================================================
// Three-stage pipelined multiplier mod P
// ==================================================
`timescale 1ns/10ps

module fp_mod_mul import ec_field_pkg::*; import ec_padd_pkg::*; (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic [FE_W-1:0]  i_a,
  input  logic [FE_W-1:0]  i_b,
  input  logic [TAG_W-1:0] i_tag,
  input  logic             i_val,
  output logic             o_rdy,
  output logic [FE_W-1:0]  o_res,
  output logic [TAG_W-1:0] o_tag,
  output logic             o_val,
  input  logic             i_rdy
);

  logic                stall;
  logic [2*FE_W-1:0]   prod_r;    // Stage 1, raw product
  logic [FE_W+4:0]     fold_r;    // Stage 2, below 2^21
  logic [TAG_W-1:0]    tag1_r;
  logic [TAG_W-1:0]    tag2_r;
  logic                v1_r;
  logic                v2_r;
  logic [2*FE_W-1:0]   fold1_c;
  logic [FE_W:0]       fold2_c;
  logic [FE_W:0]       red_c;

  // Whole pipe freezes while the output is held
  assign stall = o_val & ~i_rdy;
  assign o_rdy = ~stall;

  // hi*15 + lo, at most 983025 + 65535
  assign fold1_c = {{FE_W{1'b0}}, prod_r[2*FE_W-1:FE_W]} * {{FE_W{1'b0}}, FE_FOLD}
                 + {{FE_W{1'b0}}, prod_r[FE_W-1:0]};

  // Second fold leaves at most 66000, so one subtract of P is enough
  assign fold2_c = {{(FE_W-4){1'b0}}, fold_r[FE_W+4:FE_W]} * {1'b0, FE_FOLD}
                 + {1'b0, fold_r[FE_W-1:0]};
  assign red_c   = (fold2_c >= {1'b0, FE_P}) ? fold2_c - {1'b0, FE_P} : fold2_c;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      v1_r  <= 1'b0;
      v2_r  <= 1'b0;
      o_val <= 1'b0;
    end else if (!stall) begin
      v1_r  <= i_val;  // o_rdy is high here, so any valid is taken
      v2_r  <= v1_r;
      o_val <= v2_r;
    end
  end

  // Payload moves with the valid bits
  always_ff @(posedge i_clk) begin
    if (!stall) begin
      prod_r <= {{FE_W{1'b0}}, i_a} * {{FE_W{1'b0}}, i_b};
      tag1_r <= i_tag;
      fold_r <= fold1_c[FE_W+4:0];
      tag2_r <= tag1_r;
      o_res  <= red_c[FE_W-1:0];
      o_tag  <= tag2_r;
    end
  end

  // Two folds and one subtract always land inside the field
  a_res_in_field : assert property (@(posedge i_clk) disable iff (i_rst)
    o_val |-> (o_res < FE_P));

endmodule

//--- fp_mod_addsub.sv
// ==================================================
// Single-cycle adder/subtractor mod P
// ==================================================
`timescale 1ns/10ps

module fp_mod_addsub import ec_field_pkg::*; import ec_padd_pkg::*; (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic [FE_W-1:0]  i_a,
  input  logic [FE_W-1:0]  i_b,
  input  logic             i_sub,  // 1 = a - b, 0 = a + b
  input  logic [TAG_W-1:0] i_tag,
  input  logic             i_val,
  output logic             o_rdy,
  output logic [FE_W-1:0]  o_res,
  output logic [TAG_W-1:0] o_tag,
  output logic             o_val,
  input  logic             i_rdy
);

  logic [FE_W:0] sum_c;
  logic [FE_W:0] add_c;
  logic [FE_W:0] dif_c;
  logic [FE_W:0] sub_c;
  logic          take;

  assign sum_c = {1'b0, i_a} + {1'b0, i_b};
  assign add_c = (sum_c >= {1'b0, FE_P}) ? sum_c - {1'b0, FE_P} : sum_c;

  // Top bit set means a < b, wrap back up by P
  assign dif_c = {1'b0, i_a} - {1'b0, i_b};
  assign sub_c = dif_c[FE_W] ? dif_c + {1'b0, FE_P} : dif_c;

  assign o_rdy = ~o_val | i_rdy;  // Empty, or draining this cycle
  assign take  = i_val & o_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (take) begin
      o_val <= 1'b1;
    end else if (i_rdy) begin
      o_val <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      o_res <= i_sub ? sub_c[FE_W-1:0] : add_c[FE_W-1:0];
      o_tag <= i_tag;
    end
  end

  // Holds as long as both operands come from the field
  a_res_in_field : assert property (@(posedge i_clk) disable iff (i_rst)
    o_val |-> (o_res < FE_P));

endmodule

//--- ec_point_add.sv
// ==================================================
// Jacobian point-add sequencer with input screening
// and tagged issue to the multiplier and add/sub unit
// ==================================================
`timescale 1ns/10ps

module ec_point_add import ec_field_pkg::*; import ec_padd_pkg::*; (
  input  logic             i_clk,
  input  logic             i_rst,
  // Input points
  input  logic [FE_W-1:0]  i_p1_x, i_p1_y, i_p1_z,
  input  logic [FE_W-1:0]  i_p2_x, i_p2_y, i_p2_z,
  input  logic             i_val,
  output logic             o_rdy,
  // Result point
  output logic [FE_W-1:0]  o_p_x, o_p_y, o_p_z,
  output logic             o_val,
  output logic             o_err,
  input  logic             i_rdy,
  // Multiplier channel
  output logic [FE_W-1:0]  o_mul_a,
  output logic [FE_W-1:0]  o_mul_b,
  output logic [TAG_W-1:0] o_mul_tag,
  output logic             o_mul_val,
  input  logic             i_mul_rdy,
  input  logic [FE_W-1:0]  i_mul_res,
  input  logic [TAG_W-1:0] i_mul_tag,
  input  logic             i_mul_val,
  // Add/sub channel
  output logic [FE_W-1:0]  o_as_a,
  output logic [FE_W-1:0]  o_as_b,
  output logic             o_as_sub,
  output logic [TAG_W-1:0] o_as_tag,
  output logic             o_as_val,
  input  logic             i_as_rdy,
  input  logic [FE_W-1:0]  i_as_res,
  input  logic [TAG_W-1:0] i_as_tag,
  input  logic             i_as_val
);

  logic [1:0]       state;
  logic [N_EQ-1:0]  issued_r;  // Sent to a unit
  logic [N_EQ-1:0]  cmpl_r;    // Result back in t_r
  logic [FE_W-1:0]  t_r [N_EQ];
  logic [FE_W-1:0]  x1_r, y1_r, z1_r, x2_r, y2_r, z2_r;

  logic             p1_inf_c, p2_inf_c, x_eq_c, y_eq_c;
  logic             special_c, same_c, take;
  logic [N_EQ-1:0]  dep_ok, mul_cand, as_cand;
  logic [TAG_W-1:0] mul_sel, as_sel;
  logic [FE_W-1:0]  mul_a_c, mul_b_c, as_a_c, as_b_c;
  logic             as_sub_c, mul_go, as_go, all_done;

  // Screening, Z = 0 marks the point at infinity
  assign p1_inf_c  = (i_p1_z == '0);
  assign p2_inf_c  = (i_p2_z == '0);
  assign x_eq_c    = (i_p1_x == i_p2_x);
  assign y_eq_c    = (i_p1_y == i_p2_y);
  assign special_c = CHK_INPUT && (p1_inf_c || p2_inf_c || x_eq_c);
  assign same_c    = !p1_inf_c && !p2_inf_c && x_eq_c && y_eq_c;  // Needs doubling
  assign take      = i_val & o_rdy;
  assign all_done  = &cmpl_r;

  // Operands complete for each step
  always_comb begin
    dep_ok            = '0;
    dep_ok[EQ_Z2SQ]   = 1'b1;
    dep_ok[EQ_U1]     = cmpl_r[EQ_Z2SQ];
    dep_ok[EQ_Z1SQ]   = 1'b1;
    dep_ok[EQ_U2]     = cmpl_r[EQ_Z1SQ];
    dep_ok[EQ_Z2CU]   = cmpl_r[EQ_Z2SQ];
    dep_ok[EQ_S1]     = cmpl_r[EQ_Z2CU];
    dep_ok[EQ_Z1CU]   = cmpl_r[EQ_Z1SQ];
    dep_ok[EQ_S2]     = cmpl_r[EQ_Z1CU];
    dep_ok[EQ_H]      = cmpl_r[EQ_U1] & cmpl_r[EQ_U2];
    dep_ok[EQ_R]      = cmpl_r[EQ_S1] & cmpl_r[EQ_S2];
    dep_ok[EQ_R2]     = cmpl_r[EQ_R];
    dep_ok[EQ_H2]     = cmpl_r[EQ_H];
    dep_ok[EQ_H3]     = cmpl_r[EQ_H2];
    dep_ok[EQ_X3A]    = cmpl_r[EQ_R2] & cmpl_r[EQ_H3];
    dep_ok[EQ_U1H2]   = cmpl_r[EQ_H2];                      // U1 is in before H
    dep_ok[EQ_U1H2X2] = cmpl_r[EQ_U1H2];
    dep_ok[EQ_X3]     = cmpl_r[EQ_X3A] & cmpl_r[EQ_U1H2X2];
    dep_ok[EQ_RU]     = cmpl_r[EQ_R] & cmpl_r[EQ_U1H2];
    dep_ok[EQ_RX3]    = cmpl_r[EQ_X3];                      // R is in before X3
    dep_ok[EQ_S1H3]   = cmpl_r[EQ_S1] & cmpl_r[EQ_H3];
    dep_ok[EQ_Y3A]    = cmpl_r[EQ_RU] & cmpl_r[EQ_RX3];
    dep_ok[EQ_Y3]     = cmpl_r[EQ_Y3A] & cmpl_r[EQ_S1H3];
    dep_ok[EQ_Z12]    = 1'b1;
    dep_ok[EQ_Z3]     = cmpl_r[EQ_Z12] & cmpl_r[EQ_H];
  end

  assign mul_cand = dep_ok & ~issued_r & ~EQ_AS_MASK;
  assign as_cand  = dep_ok & ~issued_r & EQ_AS_MASK;

  // Lowest ready index wins on each unit
  always_comb begin
    mul_sel = '0;
    as_sel  = '0;
    for (int i = N_EQ - 1; i >= 0; i--) begin
      if (mul_cand[i]) mul_sel = TAG_W'(i);
      if (as_cand[i])  as_sel  = TAG_W'(i);
    end
  end

  // A register slot frees up when empty or taken this cycle
  assign mul_go = (state == ST_BUSY) && (|mul_cand) && (!o_mul_val || i_mul_rdy);
  assign as_go  = (state == ST_BUSY) && (|as_cand) && (!o_as_val || i_as_rdy);

  // Multiplier operands
  always_comb begin
    case (mul_sel)
      EQ_Z2SQ: begin mul_a_c = z2_r;         mul_b_c = z2_r;          end
      EQ_U1:   begin mul_a_c = x1_r;         mul_b_c = t_r[EQ_Z2SQ];  end
      EQ_Z1SQ: begin mul_a_c = z1_r;         mul_b_c = z1_r;          end
      EQ_U2:   begin mul_a_c = x2_r;         mul_b_c = t_r[EQ_Z1SQ];  end
      EQ_Z2CU: begin mul_a_c = t_r[EQ_Z2SQ]; mul_b_c = z2_r;          end
      EQ_S1:   begin mul_a_c = y1_r;         mul_b_c = t_r[EQ_Z2CU];  end
      EQ_Z1CU: begin mul_a_c = t_r[EQ_Z1SQ]; mul_b_c = z1_r;          end
      EQ_S2:   begin mul_a_c = y2_r;         mul_b_c = t_r[EQ_Z1CU];  end
      EQ_R2:   begin mul_a_c = t_r[EQ_R];    mul_b_c = t_r[EQ_R];     end
      EQ_H2:   begin mul_a_c = t_r[EQ_H];    mul_b_c = t_r[EQ_H];     end
      EQ_H3:   begin mul_a_c = t_r[EQ_H2];   mul_b_c = t_r[EQ_H];     end
      EQ_U1H2: begin mul_a_c = t_r[EQ_U1];   mul_b_c = t_r[EQ_H2];    end
      EQ_RU:   begin mul_a_c = t_r[EQ_R];    mul_b_c = t_r[EQ_U1H2];  end
      EQ_RX3:  begin mul_a_c = t_r[EQ_R];    mul_b_c = t_r[EQ_X3];    end
      EQ_S1H3: begin mul_a_c = t_r[EQ_S1];   mul_b_c = t_r[EQ_H3];    end
      EQ_Z12:  begin mul_a_c = z1_r;         mul_b_c = z2_r;          end
      EQ_Z3:   begin mul_a_c = t_r[EQ_Z12];  mul_b_c = t_r[EQ_H];     end
      default: begin mul_a_c = '0;           mul_b_c = '0;            end
    endcase
  end

  // Add/sub operands, only the doubling is an add
  always_comb begin
    as_sub_c = 1'b1;
    case (as_sel)
      EQ_H:      begin as_a_c = t_r[EQ_U2];    as_b_c = t_r[EQ_U1];      end
      EQ_R:      begin as_a_c = t_r[EQ_S2];    as_b_c = t_r[EQ_S1];      end
      EQ_X3A:    begin as_a_c = t_r[EQ_R2];    as_b_c = t_r[EQ_H3];      end
      EQ_U1H2X2: begin as_a_c = t_r[EQ_U1H2];  as_b_c = t_r[EQ_U1H2];  as_sub_c = 1'b0; end
      EQ_X3:     begin as_a_c = t_r[EQ_X3A];   as_b_c = t_r[EQ_U1H2X2];  end
      EQ_Y3A:    begin as_a_c = t_r[EQ_RU];    as_b_c = t_r[EQ_RX3];     end
      EQ_Y3:     begin as_a_c = t_r[EQ_Y3A];   as_b_c = t_r[EQ_S1H3];    end
      default:   begin as_a_c = '0;            as_b_c = '0;              end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= ST_IDLE;
      o_rdy     <= 1'b0;
      o_val     <= 1'b0;
      o_err     <= 1'b0;
      o_mul_val <= 1'b0;
      o_as_val  <= 1'b0;
      issued_r  <= '0;
      cmpl_r    <= '0;
    end else begin
      if (mul_go) o_mul_val <= 1'b1;
      else if (i_mul_rdy) o_mul_val <= 1'b0;
      if (as_go) o_as_val <= 1'b1;
      else if (i_as_rdy) o_as_val <= 1'b0;

      case (state)
        ST_IDLE: begin
          o_rdy <= !take;
          if (take) begin
            issued_r <= '0;
            cmpl_r   <= '0;
            if (special_c) begin
              state <= ST_DONE;  // Answer known from the screen
              o_val <= 1'b1;
              o_err <= same_c;
            end else begin
              state <= ST_BUSY;
            end
          end
        end
        ST_BUSY: begin
          if (mul_go) issued_r[mul_sel] <= 1'b1;
          if (as_go)  issued_r[as_sel]  <= 1'b1;
          if (i_mul_val) cmpl_r[i_mul_tag] <= 1'b1;
          if (i_as_val)  cmpl_r[i_as_tag]  <= 1'b1;
          if (all_done) begin
            state <= ST_DONE;
            o_val <= 1'b1;
          end
        end
        ST_DONE: begin
          if (i_rdy) begin
            state <= ST_IDLE;
            o_val <= 1'b0;
            o_err <= 1'b0;
            o_rdy <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Operand latch, temps, requests and result point
  always_ff @(posedge i_clk) begin
    if (take) begin
      x1_r <= i_p1_x;
      y1_r <= i_p1_y;
      z1_r <= i_p1_z;
      x2_r <= i_p2_x;
      y2_r <= i_p2_y;
      z2_r <= i_p2_z;
      if (p1_inf_c) begin
        o_p_x <= i_p2_x;
        o_p_y <= i_p2_y;
        o_p_z <= i_p2_z;
      end else if (p2_inf_c) begin
        o_p_x <= i_p1_x;
        o_p_y <= i_p1_y;
        o_p_z <= i_p1_z;
      end else begin
        o_p_x <= '0;  // Inverse points sum to infinity
        o_p_y <= '0;
        o_p_z <= '0;
      end
    end
    if (state == ST_BUSY) begin
      if (i_mul_val) t_r[i_mul_tag] <= i_mul_res;
      if (i_as_val)  t_r[i_as_tag]  <= i_as_res;
      if (all_done) begin
        o_p_x <= t_r[EQ_X3];
        o_p_y <= t_r[EQ_Y3];
        o_p_z <= t_r[EQ_Z3];
      end
    end
    if (mul_go) begin
      o_mul_a   <= mul_a_c;
      o_mul_b   <= mul_b_c;
      o_mul_tag <= mul_sel;
    end
    if (as_go) begin
      o_as_a   <= as_a_c;
      o_as_b   <= as_b_c;
      o_as_sub <= as_sub_c;
      o_as_tag <= as_sel;
    end
  end

  // Result held under back-pressure
  a_out_hold : assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && !i_rdy |=> o_val && $stable(o_p_x) && $stable(o_p_y) && $stable(o_p_z)
                        && $stable(o_err));

  // Each tag comes back from a unit once, and only after it went out
  a_mul_tag_once : assert property (@(posedge i_clk) disable iff (i_rst)
    i_mul_val |-> issued_r[i_mul_tag] && !cmpl_r[i_mul_tag]);
  a_as_tag_once : assert property (@(posedge i_clk) disable iff (i_rst)
    i_as_val |-> issued_r[i_as_tag] && !cmpl_r[i_as_tag]);

endmodule

//--- ec_point_add_top.sv
// ==================================================
// Point adder with its multiplier and add/sub unit
// ==================================================
`timescale 1ns/10ps

module ec_point_add_top import ec_field_pkg::*; import ec_padd_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic [FE_W-1:0] i_p1_x, i_p1_y, i_p1_z,
  input  logic [FE_W-1:0] i_p2_x, i_p2_y, i_p2_z,
  input  logic            i_val,
  output logic            o_rdy,
  output logic [FE_W-1:0] o_p_x, o_p_y, o_p_z,
  output logic            o_val,
  output logic            o_err,
  input  logic            i_rdy
);

  // Multiplier request and response
  logic [FE_W-1:0]  mul_a, mul_b, mul_res;
  logic [TAG_W-1:0] mul_tag, mul_res_tag;
  logic             mul_val, mul_rdy, mul_res_val;

  // Add/sub request and response
  logic [FE_W-1:0]  as_a, as_b, as_res;
  logic [TAG_W-1:0] as_tag, as_res_tag;
  logic             as_sub, as_val, as_rdy, as_res_val;

  ec_point_add u_seq (
    .i_clk, .i_rst,
    .i_p1_x, .i_p1_y, .i_p1_z, .i_p2_x, .i_p2_y, .i_p2_z,
    .i_val, .o_rdy,
    .o_p_x, .o_p_y, .o_p_z, .o_val, .o_err, .i_rdy,
    .o_mul_a (mul_a),  .o_mul_b (mul_b),  .o_mul_tag (mul_tag),
    .o_mul_val (mul_val), .i_mul_rdy (mul_rdy),
    .i_mul_res (mul_res), .i_mul_tag (mul_res_tag), .i_mul_val (mul_res_val),
    .o_as_a (as_a), .o_as_b (as_b), .o_as_sub (as_sub), .o_as_tag (as_tag),
    .o_as_val (as_val), .i_as_rdy (as_rdy),
    .i_as_res (as_res), .i_as_tag (as_res_tag), .i_as_val (as_res_val)
  );

  // Sequencer always sinks responses, so both units see ready tied high
  fp_mod_mul u_mul (
    .i_clk, .i_rst,
    .i_a (mul_a), .i_b (mul_b), .i_tag (mul_tag), .i_val (mul_val), .o_rdy (mul_rdy),
    .o_res (mul_res), .o_tag (mul_res_tag), .o_val (mul_res_val), .i_rdy (1'b1)
  );

  fp_mod_addsub u_addsub (
    .i_clk, .i_rst,
    .i_a (as_a), .i_b (as_b), .i_sub (as_sub), .i_tag (as_tag), .i_val (as_val),
    .o_rdy (as_rdy),
    .o_res (as_res), .o_tag (as_res_tag), .o_val (as_res_val), .i_rdy (1'b1)
  );

endmodule

//--- tb_ec_point_add.sv
// ==================================================
// Testbench for the Jacobian point adder with random
// stimulus, a reference model and assertion checks
// ==================================================
`timescale 1ns/10ps

module tb_ec_point_add import ec_field_pkg::*; ();

  localparam int SEED       = 93869;
  localparam int N_OPS      = 200;
  localparam int MAX_CYCLES = N_OPS * 200;  // Each op well under 100 cycles

  logic            clk;
  logic            rst;
  logic [FE_W-1:0] p1_x, p1_y, p1_z;
  logic [FE_W-1:0] p2_x, p2_y, p2_z;
  logic            req_val, req_rdy;
  logic [FE_W-1:0] res_x, res_y, res_z;
  logic            res_val, res_err, res_rdy;

  logic [3*FE_W:0] exp_q [$];              // {err, x, y, z} per accepted input
  logic [FE_W-1:0] exp_x, exp_y, exp_z;    // Front of the queue
  logic            exp_err;
  int              exp_cnt    = 0;
  int              n_res      = 0;
  int              val_errs   = 0;
  int              proto_errs = 0;
  int              cycles     = 0;
  int unsigned     kind;

  ec_point_add_top i_dut (
    .i_clk (clk), .i_rst (rst),
    .i_p1_x (p1_x), .i_p1_y (p1_y), .i_p1_z (p1_z),
    .i_p2_x (p2_x), .i_p2_y (p2_y), .i_p2_z (p2_z),
    .i_val (req_val), .o_rdy (req_rdy),
    .o_p_x (res_x), .o_p_y (res_y), .o_p_z (res_z),
    .o_val (res_val), .o_err (res_err), .i_rdy (res_rdy)
  );

  always #4 clk = ~clk;

  // Field arithmetic widened to 32 bits and reduced mod P
  function automatic logic [FE_W-1:0] add_mod(input logic [FE_W-1:0] a, b);
    return FE_W'((32'(a) + 32'(b)) % 32'(FE_P));
  endfunction

  function automatic logic [FE_W-1:0] sub_mod(input logic [FE_W-1:0] a, b);
    return FE_W'((32'(a) + 32'(FE_P) - 32'(b)) % 32'(FE_P));
  endfunction

  function automatic logic [FE_W-1:0] mul_mod(input logic [FE_W-1:0] a, b);
    return FE_W'((32'(a) * 32'(b)) % 32'(FE_P));
  endfunction

  function automatic logic [FE_W-1:0] rand_elem();
    return FE_W'($urandom % 32'(FE_P));
  endfunction

  function automatic logic [FE_W-1:0] rand_nonzero();
    return FE_W'(1 + $urandom % (32'(FE_P) - 1));
  endfunction

  task automatic refresh_front();
    exp_cnt = exp_q.size();
    if (exp_cnt != 0) {exp_err, exp_x, exp_y, exp_z} = exp_q[0];
  endtask

  // Reference sum from the Jacobian formulas with the special cases on top
  task automatic expect_sum(input logic [FE_W-1:0] x1, y1, z1, x2, y2, z2);
    logic [FE_W-1:0] z1s, z2s, u1, u2, s1, s2, h, r, h2, h3, u1h2, x3, y3, z3;
    logic            err;
    z1s  = mul_mod(z1, z1);
    z2s  = mul_mod(z2, z2);
    u1   = mul_mod(x1, z2s);
    u2   = mul_mod(x2, z1s);
    s1   = mul_mod(y1, mul_mod(z2s, z2));
    s2   = mul_mod(y2, mul_mod(z1s, z1));
    h    = sub_mod(u2, u1);
    r    = sub_mod(s2, s1);
    h2   = mul_mod(h, h);
    h3   = mul_mod(h2, h);
    u1h2 = mul_mod(u1, h2);
    x3   = sub_mod(sub_mod(mul_mod(r, r), h3), add_mod(u1h2, u1h2));
    y3   = sub_mod(mul_mod(r, sub_mod(u1h2, x3)), mul_mod(s1, h3));
    z3   = mul_mod(mul_mod(h, z1), z2);
    err  = 1'b0;
    if (z1 == '0) begin
      {x3, y3, z3} = {x2, y2, z2};  // P1 at infinity
    end else if (z2 == '0) begin
      {x3, y3, z3} = {x1, y1, z1};
    end else if (x1 == x2 && y1 != y2) begin
      {x3, y3, z3} = '0;            // Inverse pair
    end else if (x1 == x2) begin
      err = 1'b1;                   // Doubling only raises the flag
    end
    exp_q.push_back({err, x3, y3, z3});
    refresh_front();
  endtask

  initial begin
    void'($urandom(SEED));
    clk     = 1'b0;
    rst     = 1'b1;
    req_val = 1'b0;
    res_rdy = 1'b0;
    {p1_x, p1_y, p1_z, p2_x, p2_y, p2_z} = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < N_OPS; n++) begin
      repeat ($urandom % 3) @(negedge clk);  // Idle gap
      kind = $urandom % 10;
      p1_x = rand_elem();
      p1_y = rand_elem();
      p1_z = rand_nonzero();
      p2_x = rand_elem();
      p2_y = rand_elem();
      p2_z = rand_nonzero();
      case (kind)
        0: p1_z = '0;
        1: p2_z = '0;
        2: begin
          p2_x = p1_x;
          p2_y = add_mod(p1_y, rand_nonzero());
        end
        3: {p2_x, p2_y, p2_z} = {p1_x, p1_y, p1_z};
        default: ;
      endcase
      req_val = 1'b1;
      while (!req_rdy) @(negedge clk);  // o_rdy is registered and stable at the falling edge
      expect_sum(p1_x, p1_y, p1_z, p2_x, p2_y, p2_z);
      @(negedge clk);
      req_val = 1'b0;
    end
    while (exp_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    $display("Results %0d, value errors %0d, protocol errors %0d",
             n_res, val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Random back-pressure on the result
  always @(negedge clk) begin
    if (!rst) res_rdy = ($urandom % 4) != 0;
  end

  // Drop the front entry on each output transfer
  always @(posedge clk) begin
    if (!rst && res_val && res_rdy && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      n_res = n_res + 1;
      refresh_front();
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles with %0d results", cycles, n_res);
      $display("Some tests failed");
      $finish;
    end
  end

  a_has_exp : assert property (@(posedge clk) disable iff (rst)
    res_val && res_rdy |-> exp_cnt != 0)
    else begin
      proto_errs = proto_errs + 1;
      $display("A result came out at %0t with no input waiting for it", $time);
    end

  a_x : assert property (@(posedge clk) disable iff (rst)
    res_val && res_rdy && !exp_err |-> res_x == exp_x)
    else begin
      val_errs = val_errs + 1;
      $display("** Error at %0t: o_p_x expected %h, got %h", $time,
               $sampled(exp_x), $sampled(res_x));
    end

  a_y : assert property (@(posedge clk) disable iff (rst)
    res_val && res_rdy && !exp_err |-> res_y == exp_y)
    else begin
      val_errs = val_errs + 1;
      $display("** Error at %0t: o_p_y expected %h, got %h", $time,
               $sampled(exp_y), $sampled(res_y));
    end

  a_z : assert property (@(posedge clk) disable iff (rst)
    res_val && res_rdy && !exp_err |-> res_z == exp_z)
    else begin
      val_errs = val_errs + 1;
      $display("** Error at %0t: o_p_z expected %h, got %h", $time,
               $sampled(exp_z), $sampled(res_z));
    end

  a_err : assert property (@(posedge clk) disable iff (rst)
    res_val && res_rdy |-> res_err == exp_err)
    else begin
      val_errs = val_errs + 1;
      $display("** Error at %0t: o_err expected %b, got %b", $time,
               $sampled(exp_err), $sampled(res_err));
    end

  // Held result under back-pressure
  a_hold : assert property (@(posedge clk) disable iff (rst)
    res_val && !res_rdy |=> res_val && $stable(res_x) && $stable(res_y)
                            && $stable(res_z) && $stable(res_err))
    else begin
      proto_errs = proto_errs + 1;
      $display("Result changed at %0t while the output was stalled", $time);
    end

  a_no_rdy : assert property (@(posedge clk) disable iff (rst)
    res_val |-> !req_rdy)
    else begin
      proto_errs = proto_errs + 1;
      $display("Input ready was high at %0t while a result was waiting", $time);
    end

  a_rst_low : assert property (@(posedge clk) rst |=> !res_val && !res_err)
    else begin
      proto_errs = proto_errs + 1;
      $display("Output valid or error was high after reset at %0t", $time);
    end

endmodule

//--- sim.f
ec_field_pkg.sv
ec_padd_pkg.sv
fp_mod_mul.sv
fp_mod_addsub.sv
ec_point_add.sv
ec_point_add_top.sv
tb_ec_point_add.sv

//--- run.sh
#!/bin/sh
# Compile and run the point-add testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_ec_point_add -o tb_ec_point_add
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_ec_point_add)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1
